//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module pcm_dac_tb -f sim.f -o pcm_dac_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/pcm_dac_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1

//--- sim.f
src/pcm_pkg.sv
src/pcm_dac_regs.sv
src/pcm_rate_detect.sv
src/pcm_interp_x2.sv
src/pcm_upsampler.sv
src/pcm_dac_top.sv
test/pcm_dac_checker.sv
test/pcm_dac_tb.sv

//--- src/pcm_dac_regs.sv
`timescale 1ns/100ps

module pcm_dac_regs import pcm_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  reg_addr_t addr,
    input  pcm_t      wr_data,
    output logic      ack,
    output pcm_t      sample,
    output logic      sample_wr,
    output logic      force_en,
    output rate_e     force_rate
);

    typedef enum logic {
        idle,
        acked
    } state_e;

    state_e state;

    // capture happens on the idle -> acked transition only
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= idle;
            sample     <= '0;
            sample_wr  <= 1'b0;
            force_en   <= 1'b0;
            force_rate <= rate_x1;
        end else begin
            sample_wr <= 1'b0; // one cycle pulse
            case (state)
                idle: begin
                    if (req) begin
                        state <= acked;
                        if (addr == addr_sample) begin
                            sample    <= wr_data;
                            sample_wr <= 1'b1;
                        end else begin
                            force_en   <= wr_data[ctrl_force_bit];
                            force_rate <= rate_e'(wr_data[ctrl_rate_lsb +: 2]);
                        end
                    end
                end
                acked: begin
                    if (!req) begin
                        state <= idle; // ack drops on this edge
                    end
                end
            endcase
        end
    end

    // ack is high for the whole acked state
    assign ack = (state == acked);

endmodule

//--- src/pcm_dac_top.sv
`timescale 1ns/100ps

module pcm_dac_top import pcm_pkg::*; #(
    parameter int calc_w = 11
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  reg_addr_t addr,
    input  pcm_t      wr_data,
    input  logic      tick,
    output logic      ack,
    output rate_e     rate,
    output pcm_t      pcm_out,
    output logic      out_valid
);

    pcm_t  sample;
    logic  sample_wr;
    logic  force_en;
    rate_e force_rate;

    pcm_dac_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .addr       (addr),
        .wr_data    (wr_data),
        .ack        (ack),
        .sample     (sample),
        .sample_wr  (sample_wr),
        .force_en   (force_en),
        .force_rate (force_rate)
    );

    pcm_rate_detect u_rate (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .sample_wr  (sample_wr),
        .force_en   (force_en),
        .force_rate (force_rate),
        .rate       (rate)
    );

    pcm_upsampler #(.calc_w(calc_w)) u_ups (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .rate      (rate),
        .sample    (sample),
        .pcm_out   (pcm_out),
        .out_valid (out_valid)
    );

endmodule

//--- src/pcm_interp_x2.sv
`timescale 1ns/100ps

module pcm_interp_x2 import pcm_pkg::*; #(
    parameter int calc_w = 11
) (
    input  logic clk,
    input  logic rst,
    input  logic cen_in,
    input  logic cen_out,
    input  pcm_t snd_in,
    output pcm_t snd_out
);

    pcm_t prev;
    pcm_t curr;
    logic odd;

    logic signed [calc_w-1:0] sum;
    pcm_t mid;

    assign sum = calc_w'(prev) + calc_w'(curr); // sign extended
    assign mid = pcm_t'(sum >>> 1);             // rounds toward -inf

    always_ff @(posedge clk) begin
        if (rst) begin
            prev    <= '0;
            curr    <= '0;
            snd_out <= '0;
            odd     <= 1'b0;
        end else begin
            if (cen_out) begin
                snd_out <= odd ? mid : curr;
                odd     <= ~odd;
            end
            if (cen_in) begin
                prev <= curr;
                curr <= snd_in;
                odd  <= 1'b1; // next output is the midpoint
            end
        end
    end

endmodule

//--- src/pcm_pkg.sv
package pcm_pkg;

    // signed sample as written by the host and sent to the DAC
    typedef logic signed [8:0] pcm_t;

    // ticks seen between two sample writes, saturates at 15
    typedef logic [3:0] tick_cnt_t;

    // up-sampling ratio, one more x2 stage per step
    typedef enum logic [1:0] {
        rate_x1,
        rate_x2,
        rate_x4,
        rate_x8
    } rate_e;

    typedef logic reg_addr_t;

    localparam reg_addr_t addr_sample = 1'b0;
    localparam reg_addr_t addr_ctrl = 1'b1;

    // control word layout
    localparam int ctrl_force_bit = 0;
    localparam int ctrl_rate_lsb = 1;

endpackage

//--- src/pcm_rate_detect.sv
`timescale 1ns/100ps

module pcm_rate_detect import pcm_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  tick,
    input  logic  sample_wr,
    input  logic  force_en,
    input  rate_e force_rate,
    output rate_e rate
);

    tick_cnt_t cnt;
    rate_e     det_rate;

    // ratio from the spacing of the last two writes
    always_comb begin
        if (cnt >= tick_cnt_t'(8)) begin
            det_rate = rate_x8;
        end else if (cnt >= tick_cnt_t'(4)) begin
            det_rate = rate_x4;
        end else if (cnt >= tick_cnt_t'(2)) begin
            det_rate = rate_x2;
        end else begin
            det_rate = rate_x1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            rate <= rate_x1;
        end else begin
            if (sample_wr) begin
                // a tick in the write cycle opens the next interval
                cnt <= tick ? tick_cnt_t'(1) : '0;
            end else if (tick && cnt != '1) begin
                cnt <= cnt + tick_cnt_t'(1);
            end

            if (force_en) begin
                rate <= force_rate;
            end else if (sample_wr) begin
                rate <= det_rate; // held until the next write
            end
        end
    end

endmodule

//--- src/pcm_upsampler.sv
`timescale 1ns/100ps

module pcm_upsampler import pcm_pkg::*; #(
    parameter int calc_w = 11
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  tick,
    input  rate_e rate,
    input  pcm_t  sample,
    output pcm_t  pcm_out,
    output logic  out_valid
);

    logic [2:0] div;
    logic cen1;
    logic cen2;
    logic cen4;
    logic cen8;

    pcm_t s1_out;
    pcm_t s2_out;
    pcm_t s3_out;
    pcm_t s2_in;
    pcm_t s3_in;

    // strobes all fire on the same tick when the divider wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            div  <= '0;
            cen1 <= 1'b0;
            cen2 <= 1'b0;
            cen4 <= 1'b0;
            cen8 <= 1'b0;
        end else begin
            cen1 <= tick;
            cen2 <= tick & div[0];
            cen4 <= tick & (&div[1:0]);
            cen8 <= tick & (&div);
            if (tick) begin
                div <= div + 3'd1;
            end
        end
    end

    // skip the stages that the ratio does not use
    assign s2_in = (rate == rate_x8) ? s1_out : sample;
    assign s3_in = (rate == rate_x8 || rate == rate_x4) ? s2_out : sample;

    pcm_interp_x2 #(.calc_w(calc_w)) u_stage1 ( // x8 -> x4 rate
        .clk     (clk),
        .rst     (rst),
        .cen_in  (cen8),
        .cen_out (cen4),
        .snd_in  (sample),
        .snd_out (s1_out)
    );

    pcm_interp_x2 #(.calc_w(calc_w)) u_stage2 (
        .clk     (clk),
        .rst     (rst),
        .cen_in  (cen4),
        .cen_out (cen2),
        .snd_in  (s2_in),
        .snd_out (s2_out)
    );

    pcm_interp_x2 #(.calc_w(calc_w)) u_stage3 ( // last stage at tick rate
        .clk     (clk),
        .rst     (rst),
        .cen_in  (cen2),
        .cen_out (cen1),
        .snd_in  (s3_in),
        .snd_out (s3_out)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pcm_out   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= tick;
            if (tick) begin
                pcm_out <= (rate == rate_x1) ? sample : s3_out;
            end
        end
    end

endmodule

//--- test/pcm_dac_checker.sv
`timescale 1ns/100ps

module pcm_dac_checker import pcm_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      req,
    input reg_addr_t addr,
    input logic      ack,
    input logic      tick,
    input logic      out_valid,
    input logic      sample_wr,
    input rate_e     rate
);

    logic ctrl_cap;

    // control request taken by an idle register block
    assign ctrl_cap = req && !ack && (addr == addr_ctrl);

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req)) else $error("ack rose without req");

    ack_drop: assert property (@(posedge clk) disable iff (rst)
        $fell(req) |=> !ack) else $error("ack still high after req fell");

    valid_after_tick: assert property (@(posedge clk) disable iff (rst)
        out_valid == $past(tick)) else $error("out_valid not one cycle after tick");

    // rate moves only right after a sample write or a control write
    rate_stable: assert property (@(posedge clk) disable iff (rst)
        (rate != $past(rate)) |-> ($past(sample_wr) || $past(ctrl_cap, 2)))
        else $error("rate changed without a write");

endmodule

bind pcm_dac_top pcm_dac_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .addr      (addr),
    .ack       (ack),
    .tick      (tick),
    .out_valid (out_valid),
    .sample_wr (sample_wr),
    .rate      (rate)
);

//--- test/pcm_dac_tb.sv
`timescale 1ns/100ps

module pcm_dac_tb import pcm_pkg::*; ();

    localparam int tick_gap = 2; // cycles from tick to tick
    localparam int n_tests = 7;
    localparam int pat_const = 0;
    localparam int pat_step = 1;
    localparam int pat_random = 2;
    localparam pcm_t step_lo = pcm_t'(-200);
    localparam pcm_t step_hi = pcm_t'(150);

    // stimulus table, one entry per test in each column
    string name_tab   [n_tests] = '{"x1 random", "x2 const", "x4 const", "x8 const",
                                    "x8 step", "forced x4", "auto x2 again"};
    bit    force_tab  [n_tests] = '{0, 0, 0, 0, 0, 1, 0};
    int    spc_tab    [n_tests] = '{1, 2, 5, 9, 9, 1, 2};          // ticks per write
    int    writes_tab [n_tests] = '{16, 12, 10, 8, 12, 32, 12};
    int    settle_tab [n_tests] = '{2, 5, 5, 5, 5, 24, 5};         // first checked write
    int    pat_tab    [n_tests] = '{pat_random, pat_const, pat_const, pat_const,
                                    pat_step, pat_const, pat_const};
    int    value_tab  [n_tests] = '{0, 37, -120, 201, 0, -77, 9};
    rate_e rate_tab   [n_tests] = '{rate_x1, rate_x2, rate_x4, rate_x8,
                                    rate_x8, rate_x4, rate_x2};

    logic      clk;
    logic      rst;
    logic      req;
    reg_addr_t addr;
    pcm_t      wr_data;
    logic      tick;
    logic      ack;
    rate_e     rate;
    pcm_t      pcm_out;
    logic      out_valid;

    int          errors;
    int          tests_failed;
    logic [31:0] seed;
    int          cur_test;
    int          wr_idx;
    int          ticks_sent;
    int          valids_seen;
    pcm_t        last_sample; // what the x1 path must show
    pcm_t        prev_out;    // step output seen last

    pcm_dac_top #(.calc_w(11)) dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .addr      (addr),
        .wr_data   (wr_data),
        .tick      (tick),
        .ack       (ack),
        .rate      (rate),
        .pcm_out   (pcm_out),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic host_write(input reg_addr_t a, input pcm_t d);
        int n;
        @(posedge clk);
        addr    <= a;
        wr_data <= d;
        req     <= 1'b1;
        n = 0;
        while (!ack && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!ack) begin
            $display("host write timed out waiting for ack to rise");
            errors++;
        end
        @(posedge clk);
        req <= 1'b0;
        n = 0;
        while (ack && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            $display("host write timed out waiting for ack to fall");
            errors++;
        end
    endtask

    task automatic run_ticks(input int n);
        repeat (n) begin
            @(posedge clk);
            tick <= 1'b1;
            ticks_sent++;
            @(posedge clk);
            tick <= 1'b0;
            repeat (tick_gap - 2) @(posedge clk);
        end
    endtask

    // output monitor, reference values follow the pattern of the running test
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            valids_seen++;
        end
        if (!rst && out_valid && wr_idx >= settle_tab[cur_test]) begin
            case (pat_tab[cur_test])
                pat_const: check("pcm_out", int'(pcm_out), value_tab[cur_test]);
                pat_random: check("pcm_out", int'(pcm_out), int'(last_sample));
                default: begin
                    if (wr_idx >= writes_tab[cur_test] / 2 + 4) begin
                        check("pcm_out", int'(pcm_out), int'(step_hi)); // step settled
                    end else begin
                        // never falls, never overshoots
                        check("pcm_out in step range",
                              int'(pcm_out >= prev_out && pcm_out <= step_hi), 1);
                    end
                    prev_out = pcm_out;
                end
            endcase
        end
    end

    initial begin
        int   err_before;
        pcm_t d;
        rst     <= 1'b1;
        req     <= 1'b0;
        addr    <= addr_sample;
        wr_data <= '0;
        tick    <= 1'b0;
        errors = 0;
        tests_failed = 0;
        seed = 32'hf10a;
        cur_test = 0;
        wr_idx = 0;
        ticks_sent = 0;
        valids_seen = 0;
        last_sample = '0;
        prev_out = step_lo;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("ack", int'(ack), 0);
        check("rate", int'(rate), int'(rate_x1));

        for (int t = 0; t < n_tests; t++) begin
            err_before = errors;
            wr_idx = 0;
            prev_out = step_lo;
            cur_test = t;
            ticks_sent = 0;
            valids_seen = 0;
            // control word is {ratio, force_en}
            host_write(addr_ctrl, force_tab[t] ? pcm_t'({rate_tab[t], 1'b1}) : pcm_t'(0));
            for (int i = 0; i < writes_tab[t]; i++) begin
                wr_idx = i;
                case (pat_tab[t])
                    pat_random: begin
                        seed = xorshift(seed);
                        d = pcm_t'(seed[8:0]);
                    end
                    pat_step: d = (i < writes_tab[t] / 2) ? step_lo : step_hi;
                    default: d = pcm_t'(value_tab[t]);
                endcase
                host_write(addr_sample, d);
                last_sample = d;
                if (i >= 1) begin
                    check("rate", int'(rate), int'(rate_tab[t])); // spacing known from here
                end
                run_ticks(spc_tab[t]);
            end
            @(posedge clk); // last out_valid counted at the negedge before
            check("out_valid pulses", valids_seen, ticks_sent);
            if (errors == err_before) begin
                $display("test %0d %s: ok", t, name_tab[t]);
            end else begin
                $display("test %0d %s: %0d errors", t, name_tab[t], errors - err_before);
                tests_failed++;
            end
        end

        $display("tests: %0d passed, %0d failed", n_tests - tests_failed, tests_failed);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
